/* all.f */
hdl/aes_key_pkg.sv
hdl/key_round_ctrl.sv
hdl/key_sub_word.sv
hdl/key_round_mix.sv
hdl/aes_key_expander.sv
+incdir+tests
tests/tb_aes_key_expander.sv

/* run.sh */
#!/bin/sh
# builds the key expander testbench with verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	--top-module tb_aes_key_expander \
	-f all.f \
	-o sim_tb

# the simulator exits nonzero on a failed check, the log decides
obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log

/* tests/key_ref_model.svh */
// independent aes-128 key schedule for the testbench, included in the testbench module body
`ifndef KEY_REF_MODEL_SVH
`define KEY_REF_MODEL_SVH

logic [127:0] exp_keys [0:10];  // round keys 0..10 of the last expanded key

// product in gf(2^8), shift and add with 11b reduction
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] acc;
	logic [7:0] aa;
	acc = 8'h00;
	aa  = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i]) begin
			acc = acc ^ aa;
		end
		aa = aa[7] ? ({aa[6:0], 1'b0} ^ 8'h1b) : {aa[6:0], 1'b0};  // times x
	end
	return acc;
endfunction

// s-box entry built from scratch: inverse as x^254, then the affine map
function automatic logic [7:0] sbox_byte(input logic [7:0] x);
	logic [7:0] sq;
	logic [7:0] inv;
	sq  = x;
	inv = 8'h01;
	for (int i = 0; i < 7; i++) begin
		sq  = gf_mul(sq, sq);   // x^2, x^4 .. x^128
		inv = gf_mul(inv, sq);  // 0 stays 0
	end
	return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
		^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// rcon for round r, straight from the standard
function automatic logic [7:0] round_constant(input int r);
	case (r)
		1:       return 8'h01;
		2:       return 8'h02;
		3:       return 8'h04;
		4:       return 8'h08;
		5:       return 8'h10;
		6:       return 8'h20;
		7:       return 8'h40;
		8:       return 8'h80;
		9:       return 8'h1b;
		default: return 8'h36;  // round 10
	endcase
endfunction

// rotword then subword
function automatic logic [31:0] rot_sub_word(input logic [31:0] w);
	logic [31:0] r;
	r = {w[23:0], w[31:24]};
	return {sbox_byte(r[31:24]), sbox_byte(r[23:16]), sbox_byte(r[15:8]), sbox_byte(r[7:0])};
endfunction

// fills exp_keys with all eleven round keys of key
task automatic expand_schedule(input logic [127:0] key);
	logic [31:0] w [0:43];
	logic [31:0] temp;
	for (int i = 0; i < 4; i++) begin
		w[i] = key[127-32*i -: 32];  // w0 is the msb word
	end
	for (int i = 4; i < 44; i++) begin
		temp = w[i-1];
		if (i % 4 == 0) begin
			temp = rot_sub_word(temp) ^ {round_constant(i / 4), 24'h000000};
		end
		w[i] = w[i-4] ^ temp;
	end
	for (int r = 0; r < 11; r++) begin
		exp_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
	end
endtask

`endif

/* tests/tb_aes_key_expander.sv */
// simulation top that drives the aes-128 key expander and checks every round key against a schedule model
`timescale 1ns/1ps

module tb_aes_key_expander;
	import aes_key_pkg::*;

	localparam int VALID_WAIT = 8;   // cycles allowed for round 0 to show up
	localparam int NUM_RANDOM = 20;  // random keys run end to end

	logic                   clk;
	logic                   arst_n;
	logic                   key_strobe;
	round_key_t             key_in;
	logic                   key_valid;
	round_key_t             round_key;
	logic [ROUND_IDX_W-1:0] round_idx;
	logic                   busy;

	integer seed = 32'h7bb9_8bd3;  // fixed seed for $random

	`include "key_ref_model.svh"

	aes_key_expander uut (
		.i_clk        (clk),
		.i_arst_n     (arst_n),
		.i_key_strobe (key_strobe),
		.i_key        (key_in),
		.o_key_valid  (key_valid),
		.o_round_key  (round_key),
		.o_round_idx  (round_idx),
		.o_busy       (busy)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [127:0] expected,
			input logic [127:0] actual);
		stop_with_failure($sformatf("mismatch at %0t: %s expected %0h got %0h",
			$time, sig, expected, actual));
	endtask

	// outputs idle with the index parked at 0
	task automatic check_idle();
		assert (key_valid === 1'b0)
			else report_mismatch("o_key_valid", 128'd0, 128'(key_valid));
		assert (busy === 1'b0)
			else report_mismatch("o_busy", 128'd0, 128'(busy));
		assert (round_idx === '0)
			else report_mismatch("o_round_idx", 128'd0, 128'(round_idx));
	endtask

	// all outputs for round r as sampled at the falling edge
	task automatic check_round(input int r);
		logic [127:0] got;
		got = round_key;
		assert (key_valid === 1'b1)
			else report_mismatch("o_key_valid", 128'd1, 128'(key_valid));
		assert (round_idx === ROUND_IDX_W'(r))
			else report_mismatch("o_round_idx", 128'(r), 128'(round_idx));
		assert (busy === (r < NUM_ROUNDS))  // drops as round 10 shows
			else report_mismatch("o_busy", 128'(r < NUM_ROUNDS), 128'(busy));
		assert (got === exp_keys[r])
			else report_mismatch($sformatf("o_round_key[%0d]", r), exp_keys[r], got);
	endtask

	// one-cycle strobe from one falling edge to the next
	task automatic pulse_key(input logic [127:0] key);
		key_in     = key;
		key_strobe = 1'b1;
		@(negedge clk);
		key_strobe = 1'b0;
		key_in     = ~key;  // key must be latched, not followed
	endtask

	// waits for round 0, then walks valid until it drops
	task automatic collect_schedule();
		int waited;
		int count;
		waited = 0;
		while (key_valid !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > VALID_WAIT) begin
				stop_with_failure("timed out waiting for o_key_valid after a key strobe");
			end
		end
		assert (waited == 0)  // round 0 right after the strobe edge
			else stop_with_failure("round 0 did not appear one cycle after the strobe");
		count = 0;
		while (key_valid === 1'b1) begin
			if (count > NUM_ROUNDS) begin
				stop_with_failure("o_key_valid stayed high for more than eleven cycles");
			end
			check_round(count);
			count++;
			@(negedge clk);
		end
		assert (count == NUM_ROUNDS + 1)
			else report_mismatch("o_key_valid cycle count", 128'(NUM_ROUNDS + 1), 128'(count));
		assert (busy === 1'b0)
			else report_mismatch("o_busy", 128'd0, 128'(busy));
	endtask

	// valid must stay low in the gap between schedules
	task automatic hold_quiet(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk);
			assert (key_valid === 1'b0)
				else report_mismatch("o_key_valid", 128'd0, 128'(key_valid));
			assert (busy === 1'b0)
				else report_mismatch("o_busy", 128'd0, 128'(busy));
		end
	endtask

	task automatic draw_random_key(output logic [127:0] key);
		key = {$random(seed), $random(seed), $random(seed), $random(seed)};
	endtask

	// second strobe while round at_round of the first key is shown
	task automatic restart_during(input logic [127:0] first_key,
			input logic [127:0] second_key, input int at_round);
		expand_schedule(first_key);
		pulse_key(first_key);
		for (int r = 0; r <= at_round; r++) begin
			check_round(r);
			if (r < at_round) begin
				@(negedge clk);
			end
		end
		expand_schedule(second_key);
		pulse_key(second_key);  // new key at index 0 on the next edge
		collect_schedule();
	endtask

	initial begin
		logic [127:0] key_a;
		logic [127:0] key_b;
		arst_n     = 1'b0;
		key_strobe = 1'b0;
		key_in     = '0;
		repeat (8) @(negedge clk);  // reset for 8 cycles
		check_idle();
		arst_n = 1'b1;
		@(negedge clk);
		check_idle();

		// model checked against the published fips-197 schedule first
		expand_schedule(128'h2b7e151628aed2a6abf7158809cf4f3c);
		assert (exp_keys[1] === 128'ha0fafe1788542cb123a339392a6c7605)
			else report_mismatch("model round 1", 128'ha0fafe1788542cb123a339392a6c7605,
				exp_keys[1]);
		assert (exp_keys[10] === 128'hd014f9a8c9ee2589e13f0cc8b6630ca6)
			else report_mismatch("model round 10", 128'hd014f9a8c9ee2589e13f0cc8b6630ca6,
				exp_keys[10]);
		pulse_key(128'h2b7e151628aed2a6abf7158809cf4f3c);
		collect_schedule();
		hold_quiet(3);

		// random keys with some run back to back
		for (int k = 0; k < NUM_RANDOM; k++) begin
			draw_random_key(key_a);
			expand_schedule(key_a);
			pulse_key(key_a);
			collect_schedule();
			hold_quiet(k % 3);
		end

		// restarts early, mid-run and on the last round
		draw_random_key(key_a);
		draw_random_key(key_b);
		restart_during(key_a, key_b, 0);
		draw_random_key(key_a);
		draw_random_key(key_b);
		restart_during(key_a, key_b, 4);
		hold_quiet(2);
		draw_random_key(key_a);
		draw_random_key(key_b);
		restart_during(key_a, key_b, NUM_ROUNDS);
		hold_quiet(4);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* hdl/aes_key_expander.sv */
// iterative aes-128 key expander top, one round key per clock for eleven clocks after a key strobe
`timescale 1ns/1ps

module aes_key_expander (
	input  logic                                i_clk,
	input  logic                                i_arst_n,
	input  logic                                i_key_strobe,  // single-cycle load
	input  aes_key_pkg::round_key_t             i_key,         // 128-bit cipher key
	output logic                                o_key_valid,   // no back-pressure, take it now
	output aes_key_pkg::round_key_t             o_round_key,
	output logic [aes_key_pkg::ROUND_IDX_W-1:0] o_round_idx,   // 0..10
	output logic                                o_busy         // more keys still to come
);
	import aes_key_pkg::*;

	round_state_t state;     // sequencer to datapath
	round_key_t   cur_key;   // held round key
	key_word_u    sub_word;  // subword(rotword(w3)) back to the mixer

	key_round_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_key_strobe (i_key_strobe),
		.o_state      (state)
	);

	// substitution path off the last word
	key_sub_word u_sub (
		.i_last_word (cur_key.w3),
		.o_sub_word  (sub_word)
	);

	key_round_mix u_mix (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_key_strobe (i_key_strobe),
		.i_key        (i_key),
		.i_state      (state),
		.i_sub_word   (sub_word),
		.o_round_key  (cur_key),
		.o_key_valid  (o_key_valid)
	);

	assign o_round_key = cur_key;
	assign o_round_idx = state.round_idx;
	// low from the cycle round 10 appears
	assign o_busy      = state.active && (state.round_idx < ROUND_IDX_W'(NUM_ROUNDS));

endmodule

/* hdl/key_round_mix.sv */
// round key register and next-key xor chain, advances one aes-128 round per clock while active
`timescale 1ns/1ps

module key_round_mix (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_key_strobe,  // load i_key as round 0
	input  aes_key_pkg::round_key_t   i_key,         // cipher key
	input  aes_key_pkg::round_state_t i_state,       // from the sequencer
	input  aes_key_pkg::key_word_u    i_sub_word,    // subword(rotword(w3))
	output aes_key_pkg::round_key_t   o_round_key,   // current round key
	output logic                      o_key_valid    // o_round_key is a live schedule key
);
	import aes_key_pkg::*;

	logic [0:KEY_WORDS-1][WORD_W-1:0] cur_words;  // current key as a word array, w0 first
	logic [0:KEY_WORDS-1][WORD_W-1:0] nxt_words;  // next round key
	logic [WORD_W-1:0]                chain;      // running xor along the words
	key_word_u                        rcon_word;  // sub word with rcon folded in
	round_key_t                       key_q;      // held round key
	logic                             valid_q;
	logic                             step;       // advance to the next round

	// no step once round 10 is shown
	assign step      = i_state.active && (i_state.round_idx != ROUND_IDX_W'(NUM_ROUNDS));
	assign cur_words = key_q;

	// rcon only touches the top byte
	always_comb begin
		rcon_word          = i_sub_word;
		rcon_word.bytes[0] = i_sub_word.bytes[0] ^ i_state.rcon;
	end

	// w'[i] = w'[i-1] ^ w[i], with w'[-1] standing in for the rcon word
	always_comb begin
		chain = rcon_word.word;
		for (int i = 0; i < KEY_WORDS; i++) begin
			chain        = chain ^ cur_words[i];
			nxt_words[i] = chain;
		end
	end

	// payload register
	always_ff @(posedge i_clk) begin
		if (i_key_strobe) begin
			key_q <= i_key;  // new key wins over a running schedule
		end else if (step) begin
			key_q <= round_key_t'(nxt_words);
		end
	end

	// valid spans rounds 0..10, drops the clock after round 10 shows
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else if (i_key_strobe) begin
			valid_q <= 1'b1;
		end else begin
			valid_q <= step;
		end
	end

	assign o_round_key = key_q;
	assign o_key_valid = valid_q;

endmodule

/* hdl/key_sub_word.sv */
// rotword and subword on the last word of the current round key, purely combinational
`timescale 1ns/1ps

module key_sub_word (
	input  aes_key_pkg::key_word_u i_last_word,  // w3 of current round key
	output aes_key_pkg::key_word_u o_sub_word    // subword(rotword(w3))
);
	import aes_key_pkg::*;

	key_word_u rot_word;  // w3 rotated left by one byte

	// top byte wraps to the bottom
	assign rot_word.word = {i_last_word.word[WORD_W-BYTE_W-1:0], i_last_word.bytes[0]};

	// four parallel s-box reads, one per byte lane
	always_comb begin
		for (int b = 0; b < WORD_W/BYTE_W; b++) begin
			o_sub_word.bytes[b] = sbox_lookup(rot_word.bytes[b]);
		end
	end

endmodule

/* hdl/key_round_ctrl.sv */
// round sequencer for the key expander, steps the round index and rcon once per clock after a load
`timescale 1ns/1ps

module key_round_ctrl (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_key_strobe,  // load pulse, restarts any expansion
	output aes_key_pkg::round_state_t o_state        // index, rcon, active
);
	import aes_key_pkg::*;

	round_state_t state_q;     // registered sequencer state
	round_state_t state_d;     // next state
	logic         last_round;  // round 10 is on the output

	// multiply by x in gf(2^8)
	function automatic logic [BYTE_W-1:0] gf_double(input logic [BYTE_W-1:0] val);
		logic [BYTE_W-1:0] shifted;
		shifted = {val[BYTE_W-2:0], 1'b0};
		return val[BYTE_W-1] ? (shifted ^ RCON_POLY) : shifted;  // reduce on carry out
	endfunction

	assign last_round = (state_q.round_idx == ROUND_IDX_W'(NUM_ROUNDS));

	always_comb begin
		state_d = state_q;  // hold by default
		if (i_key_strobe) begin
			state_d.round_idx = '0;         // key itself is round 0
			state_d.rcon      = RCON_INIT;  // used to build round 1
			state_d.active    = 1'b1;
		end else if (state_q.active) begin
			if (last_round) begin
				state_d.active = 1'b0;  // schedule done, idx stays at 10
			end else begin
				state_d.round_idx = state_q.round_idx + 1'b1;
				state_d.rcon      = gf_double(state_q.rcon);  // 01 02 04 .. 80 1b 36
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= '0;  // idle, idx 0
		end else begin
			state_q <= state_d;
		end
	end

	assign o_state = state_q;

endmodule

/* hdl/aes_key_pkg.sv */
// shared widths, key types and forward s-box for the aes-128 key expander, imported by every rtl file
package aes_key_pkg;

	localparam int WORD_W      = 32;  // bits per key word
	localparam int BYTE_W      = 8;   // bits per byte
	localparam int KEY_WORDS   = 4;   // words per round key
	localparam int NUM_ROUNDS  = 10;  // rounds after round 0
	localparam int ROUND_IDX_W = 4;   // holds 0..10

	localparam logic [BYTE_W-1:0] RCON_INIT = 8'h01;  // rcon of round 1
	localparam logic [BYTE_W-1:0] RCON_POLY = 8'h1b;  // x^8 reduction, low byte

	// one key word, seen whole by the xor chain or bytewise by the s-box path
	typedef union packed {
		logic [WORD_W-1:0]                      word;   // plain 32-bit view
		logic [0:WORD_W/BYTE_W-1][BYTE_W-1:0]   bytes;  // bytes[0] is the msb
	} key_word_u;

	typedef struct packed {
		key_word_u w0;  // first word, msbs of the 128-bit key
		key_word_u w1;
		key_word_u w2;
		key_word_u w3;  // last word, feeds rotword/subword
	} round_key_t;

	typedef struct packed {
		logic [ROUND_IDX_W-1:0] round_idx;  // index of key on the output
		logic [BYTE_W-1:0]      rcon;       // rcon for the next round
		logic                   active;     // expansion in progress
	} round_state_t;

	// forward aes substitution, row major by high nibble
	localparam logic [BYTE_W-1:0] SBOX [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// plain table read, synthesizes to a 256x8 rom
	function automatic logic [BYTE_W-1:0] sbox_lookup(input logic [BYTE_W-1:0] in_byte);
		return SBOX[in_byte];
	endfunction

endpackage
